// ==== verilog/buf_mgr_pkg.sv ====
package buf_mgr_pkg;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------

    typedef logic [3:0]  buf_index_t;
    typedef logic [31:0] buf_addr_t;
    typedef logic [3:0]  refcnt_t;

    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;

    // one claim or one release of a buffer in a cycle
    typedef struct packed {
        logic       acquire;
        logic       rel;
        buf_index_t index;
    } buf_event_t;

    // ----------------------------------------
    // register map
    // ----------------------------------------

    localparam wb_adr_t ADR_CORE_ID       = 8'h00;
    localparam wb_adr_t ADR_CORE_CONFIG   = 8'h03;
    localparam wb_adr_t ADR_NEWEST_INDEX  = 8'h20;
    localparam wb_adr_t ADR_WRITER_INDEX  = 8'h21;

    // base of a block, plus the buffer index
    localparam wb_adr_t ADR_BUFFER_ADDR   = 8'h40;
    localparam wb_adr_t ADR_BUFFER_REFCNT = 8'h80;

    localparam wb_dat_t CORE_ID = 32'h527a_f100;

endpackage

// ==== verilog/buf_writer_alloc.sv ====
`timescale 1ns/1ps

module buf_writer_alloc #(
    parameter int BUFFER_NUM = 4
) (
    input  logic                                     s_wb_clk_i,
    input  logic                                     s_wb_rst_i,
    input  logic                                     writer_request_i,
    input  logic                                     writer_release_i,
    input  buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]    refcnt_i,
    output logic                                     writer_busy_o,
    output buf_mgr_pkg::buf_index_t                  writer_index_o,
    output buf_mgr_pkg::buf_index_t                  newest_index_o,
    output buf_mgr_pkg::buf_event_t                  writer_evt_o,
    output buf_mgr_pkg::buf_event_t                  newest_drop_o
);

    logic                    free_found;
    buf_mgr_pkg::buf_index_t free_index;
    logic                    take_req;
    logic                    take_rel;

    // lowest index with no holder wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int b = BUFFER_NUM - 1; b >= 0; b--) begin
            if (refcnt_i[b] == '0) begin
                free_found = 1'b1;
                free_index = buf_mgr_pkg::buf_index_t'(b);
            end
        end
    end

    assign take_req = writer_request_i && !writer_busy_o && free_found;
    assign take_rel = writer_release_i && writer_busy_o;

    // writer ref turns into the newest ref on release, so only acquire here
    assign writer_evt_o.acquire = take_req;
    assign writer_evt_o.rel     = 1'b0;
    assign writer_evt_o.index   = free_index;

    assign newest_drop_o.acquire = 1'b0;
    assign newest_drop_o.rel     = take_rel;
    assign newest_drop_o.index   = newest_index_o;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            writer_busy_o  <= 1'b0;
            writer_index_o <= '0;
            newest_index_o <= '0;
        end else if (take_req) begin
            writer_busy_o  <= 1'b1;
            writer_index_o <= free_index;
        end else if (take_rel) begin
            writer_busy_o  <= 1'b0;
            newest_index_o <= writer_index_o;
        end
    end

endmodule

// ==== verilog/buf_reader_alloc.sv ====
`timescale 1ns/1ps

module buf_reader_alloc #(
    parameter int READER_NUM = 2
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  logic [READER_NUM-1:0]                       reader_request_i,
    input  logic [READER_NUM-1:0]                       reader_release_i,
    input  buf_mgr_pkg::buf_index_t                     newest_index_i,
    output logic [READER_NUM-1:0]                       reader_busy_o,
    output buf_mgr_pkg::buf_index_t [READER_NUM-1:0]    reader_index_o,
    output buf_mgr_pkg::buf_event_t [READER_NUM-1:0]    reader_evt_o
);

    logic [READER_NUM-1:0] take_req;
    logic [READER_NUM-1:0] take_rel;

    assign take_req = reader_request_i & ~reader_busy_o;
    assign take_rel = reader_release_i & reader_busy_o;

    // at most one of acquire and release per reader and cycle
    always_comb begin
        for (int r = 0; r < READER_NUM; r++) begin
            reader_evt_o[r].acquire = take_req[r];
            reader_evt_o[r].rel     = take_rel[r];
            if (take_req[r]) begin
                reader_evt_o[r].index = newest_index_i;
            end else begin
                reader_evt_o[r].index = reader_index_o[r];
            end
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            reader_busy_o  <= '0;
            reader_index_o <= '0;
        end else begin
            for (int r = 0; r < READER_NUM; r++) begin
                if (take_req[r]) begin
                    reader_busy_o[r]  <= 1'b1;
                    reader_index_o[r] <= newest_index_i;
                end else if (take_rel[r]) begin
                    reader_busy_o[r] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== verilog/buf_refcnt_table.sv ====
`timescale 1ns/1ps

module buf_refcnt_table #(
    parameter int BUFFER_NUM = 4,
    parameter int READER_NUM = 2
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  buf_mgr_pkg::buf_event_t                     writer_evt_i,
    input  buf_mgr_pkg::buf_event_t                     newest_drop_i,
    input  buf_mgr_pkg::buf_event_t [READER_NUM-1:0]    reader_evt_i,
    output buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]       refcnt_o
);

    localparam int EVT_NUM = READER_NUM + 2;

    buf_mgr_pkg::buf_event_t [EVT_NUM-1:0]    evt_all;
    buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]    cnt_next;

    assign evt_all = {reader_evt_i, newest_drop_i, writer_evt_i};

    // ----------------------------------------
    // next count per buffer
    // ----------------------------------------

    // several events may hit the same buffer in one cycle
    always_comb begin
        for (int b = 0; b < BUFFER_NUM; b++) begin
            cnt_next[b] = refcnt_o[b];
            for (int e = 0; e < EVT_NUM; e++) begin
                if (evt_all[e].index == buf_mgr_pkg::buf_index_t'(b)) begin
                    if (evt_all[e].acquire) begin
                        cnt_next[b] = cnt_next[b] + 1'b1;
                    end
                    if (evt_all[e].rel) begin
                        cnt_next[b] = cnt_next[b] - 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // count registers
    // ----------------------------------------

    // buffer 0 starts as the newest, so it holds one reference
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            for (int b = 0; b < BUFFER_NUM; b++) begin
                refcnt_o[b] <= (b == 0) ? 4'd1 : 4'd0;
            end
        end else begin
            refcnt_o <= cnt_next;
        end
    end

endmodule

// ==== verilog/buf_mgr_regs.sv ====
`timescale 1ns/1ps

module buf_mgr_regs #(
    parameter int BUFFER_NUM = 4,
    parameter int READER_NUM = 2
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  buf_mgr_pkg::wb_adr_t                        s_wb_adr_i,
    input  buf_mgr_pkg::wb_dat_t                        s_wb_dat_i,
    output buf_mgr_pkg::wb_dat_t                        s_wb_dat_o,
    input  logic                                        s_wb_we_i,
    input  buf_mgr_pkg::wb_sel_t                        s_wb_sel_i,
    input  logic                                        s_wb_stb_i,
    output logic                                        s_wb_ack_o,
    input  buf_mgr_pkg::buf_index_t                     writer_index_i,
    input  buf_mgr_pkg::buf_index_t [READER_NUM-1:0]    reader_index_i,
    input  buf_mgr_pkg::buf_index_t                     newest_index_i,
    input  buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]       refcnt_i,
    output buf_mgr_pkg::buf_addr_t                      writer_addr_o,
    output buf_mgr_pkg::buf_addr_t [READER_NUM-1:0]     reader_addr_o,
    output buf_mgr_pkg::buf_addr_t                      newest_addr_o
);

    buf_mgr_pkg::buf_addr_t [BUFFER_NUM-1:0] buf_addr_q;

    function automatic buf_mgr_pkg::buf_addr_t addr_of(input buf_mgr_pkg::buf_index_t idx);
        buf_mgr_pkg::buf_addr_t a;
        a = '0;
        for (int b = 0; b < BUFFER_NUM; b++) begin
            if (idx == buf_mgr_pkg::buf_index_t'(b)) begin
                a = buf_addr_q[b];
            end
        end
        return a;
    endfunction

    // ----------------------------------------
    // buffer base addresses
    // ----------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            for (int b = 0; b < BUFFER_NUM; b++) begin
                buf_addr_q[b] <= buf_mgr_pkg::buf_addr_t'(b) << 20;
            end
        end else if (s_wb_stb_i && s_wb_we_i) begin
            for (int b = 0; b < BUFFER_NUM; b++) begin
                if (s_wb_adr_i == buf_mgr_pkg::ADR_BUFFER_ADDR + buf_mgr_pkg::wb_adr_t'(b)) begin
                    // byte lanes
                    for (int k = 0; k < 4; k++) begin
                        if (s_wb_sel_i[k]) begin
                            buf_addr_q[b][8*k +: 8] <= s_wb_dat_i[8*k +: 8];
                        end
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // read mux and lookups
    // ----------------------------------------

    always_comb begin
        case (s_wb_adr_i)
            buf_mgr_pkg::ADR_CORE_ID:      s_wb_dat_o = buf_mgr_pkg::CORE_ID;
            buf_mgr_pkg::ADR_CORE_CONFIG:  s_wb_dat_o = buf_mgr_pkg::wb_dat_t'(BUFFER_NUM);
            buf_mgr_pkg::ADR_NEWEST_INDEX: s_wb_dat_o = {28'd0, newest_index_i};
            buf_mgr_pkg::ADR_WRITER_INDEX: s_wb_dat_o = {28'd0, writer_index_i};
            default:                       s_wb_dat_o = '0;
        endcase
        for (int b = 0; b < BUFFER_NUM; b++) begin
            if (s_wb_adr_i == buf_mgr_pkg::ADR_BUFFER_ADDR + buf_mgr_pkg::wb_adr_t'(b)) begin
                s_wb_dat_o = buf_addr_q[b];
            end
            if (s_wb_adr_i == buf_mgr_pkg::ADR_BUFFER_REFCNT + buf_mgr_pkg::wb_adr_t'(b)) begin
                s_wb_dat_o = {28'd0, refcnt_i[b]};
            end
        end
    end

    always_comb begin
        writer_addr_o = addr_of(writer_index_i);
        newest_addr_o = addr_of(newest_index_i);
        for (int r = 0; r < READER_NUM; r++) begin
            reader_addr_o[r] = addr_of(reader_index_i[r]);
        end
    end

    // always ready
    assign s_wb_ack_o = s_wb_stb_i;

endmodule

// ==== verilog/buf_manager.sv ====
`timescale 1ns/1ps

module buf_manager #(
    parameter int BUFFER_NUM = 4,
    parameter int READER_NUM = 2
) (
    input  logic                                        s_wb_clk_i,
    input  logic                                        s_wb_rst_i,
    input  buf_mgr_pkg::wb_adr_t                        s_wb_adr_i,
    input  buf_mgr_pkg::wb_dat_t                        s_wb_dat_i,
    output buf_mgr_pkg::wb_dat_t                        s_wb_dat_o,
    input  logic                                        s_wb_we_i,
    input  buf_mgr_pkg::wb_sel_t                        s_wb_sel_i,
    input  logic                                        s_wb_stb_i,
    output logic                                        s_wb_ack_o,

    input  logic                                        writer_request_i,
    input  logic                                        writer_release_i,
    output logic                                        writer_busy_o,
    output buf_mgr_pkg::buf_index_t                     writer_index_o,
    output buf_mgr_pkg::buf_addr_t                      writer_addr_o,

    input  logic [READER_NUM-1:0]                       reader_request_i,
    input  logic [READER_NUM-1:0]                       reader_release_i,
    output logic [READER_NUM-1:0]                       reader_busy_o,
    output buf_mgr_pkg::buf_index_t [READER_NUM-1:0]    reader_index_o,
    output buf_mgr_pkg::buf_addr_t [READER_NUM-1:0]     reader_addr_o,

    output buf_mgr_pkg::buf_index_t                     newest_index_o,
    output buf_mgr_pkg::buf_addr_t                      newest_addr_o
);

    buf_mgr_pkg::buf_event_t                     writer_evt;
    buf_mgr_pkg::buf_event_t                     newest_drop;
    buf_mgr_pkg::buf_event_t [READER_NUM-1:0]    reader_evt;
    buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]       refcnt;

    // ----------------------------------------
    // allocators
    // ----------------------------------------

    buf_writer_alloc #(
        .BUFFER_NUM (BUFFER_NUM)
    ) writer_alloc_inst (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .writer_request_i (writer_request_i),
        .writer_release_i (writer_release_i),
        .refcnt_i         (refcnt),
        .writer_busy_o    (writer_busy_o),
        .writer_index_o   (writer_index_o),
        .newest_index_o   (newest_index_o),
        .writer_evt_o     (writer_evt),
        .newest_drop_o    (newest_drop)
    );

    buf_reader_alloc #(
        .READER_NUM (READER_NUM)
    ) reader_alloc_inst (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .reader_request_i (reader_request_i),
        .reader_release_i (reader_release_i),
        .newest_index_i   (newest_index_o),
        .reader_busy_o    (reader_busy_o),
        .reader_index_o   (reader_index_o),
        .reader_evt_o     (reader_evt)
    );

    // ----------------------------------------
    // counts and registers
    // ----------------------------------------

    buf_refcnt_table #(
        .BUFFER_NUM (BUFFER_NUM),
        .READER_NUM (READER_NUM)
    ) refcnt_table_inst (
        .s_wb_clk_i    (s_wb_clk_i),
        .s_wb_rst_i    (s_wb_rst_i),
        .writer_evt_i  (writer_evt),
        .newest_drop_i (newest_drop),
        .reader_evt_i  (reader_evt),
        .refcnt_o      (refcnt)
    );

    buf_mgr_regs #(
        .BUFFER_NUM (BUFFER_NUM),
        .READER_NUM (READER_NUM)
    ) regs_inst (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .s_wb_adr_i     (s_wb_adr_i),
        .s_wb_dat_i     (s_wb_dat_i),
        .s_wb_dat_o     (s_wb_dat_o),
        .s_wb_we_i      (s_wb_we_i),
        .s_wb_sel_i     (s_wb_sel_i),
        .s_wb_stb_i     (s_wb_stb_i),
        .s_wb_ack_o     (s_wb_ack_o),
        .writer_index_i (writer_index_o),
        .reader_index_i (reader_index_o),
        .newest_index_i (newest_index_o),
        .refcnt_i       (refcnt),
        .writer_addr_o  (writer_addr_o),
        .reader_addr_o  (reader_addr_o),
        .newest_addr_o  (newest_addr_o)
    );

endmodule

// ==== sim/buf_mgr_clkgen.sv ====
`timescale 1ns/1ps

module buf_mgr_clkgen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over five rising edges
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== sim/buf_manager_properties.sv ====
`timescale 1ns/1ps

module buf_manager_properties #(
    parameter int BUFFER_NUM = 4,
    parameter int READER_NUM = 2
) (
    input  logic                                     s_wb_clk_i,
    input  logic                                     s_wb_rst_i,
    input  logic                                     stb_i,
    input  logic                                     ack_i,
    input  logic                                     writer_busy_i,
    input  buf_mgr_pkg::buf_index_t                  writer_index_i,
    input  buf_mgr_pkg::buf_index_t                  newest_index_i,
    input  buf_mgr_pkg::refcnt_t [BUFFER_NUM-1:0]    refcnt_i
);

    ack_follows_stb: assert property (@(posedge s_wb_clk_i) ack_i == stb_i)
        else $error("ack differs from stb");

    // writer, every reader and the newest slot at most
    for (genvar b = 0; b < BUFFER_NUM; b++) begin : g_count
        count_bound: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
            refcnt_i[b] <= READER_NUM + 2)
            else $error("buffer %0d count %0d above holder limit", b, refcnt_i[b]);
    end

    writer_not_newest: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        writer_busy_i |-> writer_index_i != newest_index_i)
        else $error("writer holds the newest buffer %0d", newest_index_i);

endmodule

bind buf_manager buf_manager_properties #(
    .BUFFER_NUM (BUFFER_NUM),
    .READER_NUM (READER_NUM)
) properties_inst (
    .s_wb_clk_i     (s_wb_clk_i),
    .s_wb_rst_i     (s_wb_rst_i),
    .stb_i          (s_wb_stb_i),
    .ack_i          (s_wb_ack_o),
    .writer_busy_i  (writer_busy_o),
    .writer_index_i (writer_index_o),
    .newest_index_i (newest_index_o),
    .refcnt_i       (refcnt)
);

// ==== sim/buf_manager_tb.sv ====
`timescale 1ns/1ps

module buf_manager_tb;

    localparam int BUFFER_NUM = 4;
    localparam int READER_NUM = 2;

    typedef enum logic [2:0] {
        OP_IDLE, OP_WR_REQ, OP_WR_REL, OP_RD_REQ, OP_RD_REL, OP_BUS_WR, OP_BUS_RD
    } op_t;

    typedef struct packed {
        op_t                                        op;
        logic [3:0]                                 reader;
        buf_mgr_pkg::wb_adr_t                       adr;
        buf_mgr_pkg::wb_dat_t                       dat;
        buf_mgr_pkg::wb_sel_t                       sel;
        buf_mgr_pkg::wb_dat_t                       exp_dat;
        logic                                       exp_wbusy;
        buf_mgr_pkg::buf_index_t                    exp_windex;
        buf_mgr_pkg::buf_index_t                    exp_newest;
        logic [READER_NUM-1:0]                      exp_rbusy;
        buf_mgr_pkg::buf_index_t [READER_NUM-1:0]   exp_rindex;
        buf_mgr_pkg::buf_addr_t                     exp_waddr;
        buf_mgr_pkg::buf_addr_t                     exp_naddr;
        buf_mgr_pkg::buf_addr_t [READER_NUM-1:0]    exp_raddr;
    } row_t;

    logic                                       s_wb_clk_i;
    logic                                       s_wb_rst_i;
    buf_mgr_pkg::wb_adr_t                       s_wb_adr_i;
    buf_mgr_pkg::wb_dat_t                       s_wb_dat_i;
    buf_mgr_pkg::wb_dat_t                       s_wb_dat_o;
    logic                                       s_wb_we_i;
    buf_mgr_pkg::wb_sel_t                       s_wb_sel_i;
    logic                                       s_wb_stb_i;
    logic                                       s_wb_ack_o;
    logic                                       writer_request_i;
    logic                                       writer_release_i;
    logic                                       writer_busy_o;
    buf_mgr_pkg::buf_index_t                    writer_index_o;
    buf_mgr_pkg::buf_addr_t                     writer_addr_o;
    logic [READER_NUM-1:0]                      reader_request_i;
    logic [READER_NUM-1:0]                      reader_release_i;
    logic [READER_NUM-1:0]                      reader_busy_o;
    buf_mgr_pkg::buf_index_t [READER_NUM-1:0]   reader_index_o;
    buf_mgr_pkg::buf_addr_t [READER_NUM-1:0]    reader_addr_o;
    buf_mgr_pkg::buf_index_t                    newest_index_o;
    buf_mgr_pkg::buf_addr_t                     newest_addr_o;

    // reference model of the holder counts
    int                    m_cnt [BUFFER_NUM];
    logic [31:0]           m_addr [BUFFER_NUM];
    int                    m_newest;
    logic                  m_wbusy;
    int                    m_windex;
    logic [READER_NUM-1:0] m_rbusy;
    int                    m_rindex [READER_NUM];
    row_t                  table_q [$];
    int                    checks;
    int                    errors;

    buf_mgr_clkgen clkgen_inst (
        .clk_o (s_wb_clk_i),
        .rst_o (s_wb_rst_i)
    );

    buf_manager #(
        .BUFFER_NUM (BUFFER_NUM),
        .READER_NUM (READER_NUM)
    ) buf_manager_inst (.*);

    function automatic logic [31:0] read_model(input int adr);
        logic [31:0] v;
        case (adr)
            buf_mgr_pkg::ADR_CORE_ID:      v = buf_mgr_pkg::CORE_ID;
            buf_mgr_pkg::ADR_CORE_CONFIG:  v = BUFFER_NUM;
            buf_mgr_pkg::ADR_NEWEST_INDEX: v = m_newest;
            buf_mgr_pkg::ADR_WRITER_INDEX: v = m_windex;
            default:                       v = 32'h0;
        endcase
        for (int b = 0; b < BUFFER_NUM; b++) begin
            if (adr == buf_mgr_pkg::ADR_BUFFER_ADDR + b) v = m_addr[b];
            if (adr == buf_mgr_pkg::ADR_BUFFER_REFCNT + b) v = m_cnt[b];
        end
        return v;
    endfunction

    // apply one operation to the model and store the row with its expected outputs
    task automatic add_row(input op_t op, input int r, input int adr,
                           input logic [31:0] dat, input logic [3:0] sel);
        row_t        rw;
        int          f;
        logic [31:0] mask;
        rw = '0;
        rw.op = op;
        rw.reader = r[3:0];
        rw.adr = buf_mgr_pkg::wb_adr_t'(adr);
        rw.dat = dat;
        rw.sel = sel;
        rw.exp_dat = read_model(adr);
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        f = -1;
        for (int b = 0; b < BUFFER_NUM && f < 0; b++) begin
            if (m_cnt[b] == 0) f = b;
        end
        case (op)
            OP_WR_REQ: if (!m_wbusy && f >= 0) begin
                m_wbusy = 1'b1;
                m_windex = f;
                m_cnt[f]++;
            end
            OP_WR_REL: if (m_wbusy) begin
                m_cnt[m_newest]--;
                m_newest = m_windex;
                m_wbusy = 1'b0;
            end
            OP_RD_REQ: if (!m_rbusy[r]) begin
                m_rbusy[r] = 1'b1;
                m_rindex[r] = m_newest;
                m_cnt[m_newest]++;
            end
            OP_RD_REL: if (m_rbusy[r]) begin
                m_rbusy[r] = 1'b0;
                m_cnt[m_rindex[r]]--;
            end
            OP_BUS_WR: for (int b = 0; b < BUFFER_NUM; b++) begin
                if (adr == buf_mgr_pkg::ADR_BUFFER_ADDR + b) begin
                    m_addr[b] = (m_addr[b] & ~mask) | (dat & mask);
                end
            end
            default: ;
        endcase
        rw.exp_wbusy = m_wbusy;
        rw.exp_windex = buf_mgr_pkg::buf_index_t'(m_windex);
        rw.exp_newest = buf_mgr_pkg::buf_index_t'(m_newest);
        rw.exp_rbusy = m_rbusy;
        for (int q = 0; q < READER_NUM; q++) begin
            rw.exp_rindex[q] = buf_mgr_pkg::buf_index_t'(m_rindex[q]);
            rw.exp_raddr[q] = m_addr[m_rindex[q]];
        end
        rw.exp_waddr = m_addr[m_windex];
        rw.exp_naddr = m_addr[m_newest];
        table_q.push_back(rw);
    endtask

    task automatic add_read(input int adr);
        add_row(OP_BUS_RD, 0, adr, 32'h0, 4'h0);
    endtask

    task automatic add_op(input op_t op, input int r);
        add_row(op, r, 0, 32'h0, 4'h0);
    endtask

    task automatic drive_row(input row_t rw);
        s_wb_adr_i = rw.adr;
        s_wb_dat_i = rw.dat;
        s_wb_sel_i = rw.sel;
        s_wb_we_i = (rw.op == OP_BUS_WR);
        s_wb_stb_i = (rw.op == OP_BUS_WR) || (rw.op == OP_BUS_RD);
        writer_request_i = (rw.op == OP_WR_REQ);
        writer_release_i = (rw.op == OP_WR_REL);
        reader_request_i = '0;
        reader_release_i = '0;
        reader_request_i[rw.reader] = (rw.op == OP_RD_REQ);
        reader_release_i[rw.reader] = (rw.op == OP_RD_REL);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic verify_outputs(input row_t rw);
        compare_value("writer_busy_o", writer_busy_o, rw.exp_wbusy);
        compare_value("writer_index_o", writer_index_o, rw.exp_windex);
        compare_value("newest_index_o", newest_index_o, rw.exp_newest);
        compare_value("reader_busy_o", reader_busy_o, rw.exp_rbusy);
        compare_value("reader_index_o", reader_index_o, rw.exp_rindex);
        compare_value("writer_addr_o", writer_addr_o, rw.exp_waddr);
        compare_value("newest_addr_o", newest_addr_o, rw.exp_naddr);
        for (int r = 0; r < READER_NUM; r++) begin
            compare_value($sformatf("reader_addr_o[%0d]", r), reader_addr_o[r],
                          rw.exp_raddr[r]);
        end
    endtask

    // ----------------------------------------
    // table build and run
    // ----------------------------------------

    initial begin
        int          wait_cycles;
        logic [31:0] word;
        checks = 0;
        errors = 0;
        drive_row('0);
        void'($urandom(59));
        for (int b = 0; b < BUFFER_NUM; b++) begin
            m_cnt[b] = (b == 0) ? 1 : 0;
            m_addr[b] = b * 32'h0010_0000;
        end
        m_newest = 0;
        m_wbusy = 1'b0;
        m_windex = 0;
        m_rbusy = '0;
        for (int r = 0; r < READER_NUM; r++) begin
            m_rindex[r] = 0;
        end

        // reset values
        add_read(buf_mgr_pkg::ADR_CORE_ID);
        add_read(buf_mgr_pkg::ADR_CORE_CONFIG);
        add_read(buf_mgr_pkg::ADR_NEWEST_INDEX);
        add_read(buf_mgr_pkg::ADR_WRITER_INDEX);
        for (int b = 0; b < BUFFER_NUM; b++) begin
            add_read(buf_mgr_pkg::ADR_BUFFER_ADDR + b);
            add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT + b);
        end

        // partial byte writes
        word = $urandom();
        add_row(OP_BUS_WR, 0, buf_mgr_pkg::ADR_BUFFER_ADDR, word, 4'b0101);
        add_read(buf_mgr_pkg::ADR_BUFFER_ADDR);
        word = $urandom();
        add_row(OP_BUS_WR, 0, buf_mgr_pkg::ADR_BUFFER_ADDR + 2, word, 4'b1000);
        add_read(buf_mgr_pkg::ADR_BUFFER_ADDR + 2);

        add_op(OP_WR_REQ, 0);
        add_read(buf_mgr_pkg::ADR_WRITER_INDEX);
        add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT + 1);
        add_op(OP_WR_REL, 0);
        add_op(OP_RD_REQ, 0);
        add_read(buf_mgr_pkg::ADR_NEWEST_INDEX);
        add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT);
        add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT + 1);

        // requests and releases that do not fit the holder state
        add_op(OP_RD_REQ, 0);
        add_op(OP_WR_REL, 0);
        add_op(OP_RD_REL, 1);
        add_op(OP_WR_REQ, 0);
        add_op(OP_WR_REQ, 0);
        add_op(OP_WR_REL, 0);

        for (int i = 0; i < 8; i++) begin
            add_op(OP_WR_REQ, 0);
            if (i % 3 == 0) begin
                word = $urandom();
                add_row(OP_BUS_WR, 0, buf_mgr_pkg::ADR_BUFFER_ADDR + i % BUFFER_NUM, word, 4'hf);
            end
            add_op(OP_WR_REL, 0);
            add_op(m_rbusy[i % READER_NUM] ? OP_RD_REL : OP_RD_REQ, i % READER_NUM);
            for (int b = 0; b < BUFFER_NUM; b++) begin
                add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT + b);
            end
        end
        add_op(OP_RD_REL, 0);
        add_op(OP_RD_REL, 1);
        for (int b = 0; b < BUFFER_NUM; b++) begin
            add_read(buf_mgr_pkg::ADR_BUFFER_REFCNT + b);
        end

        wait_cycles = 0;
        do begin
            @(posedge s_wb_clk_i);
            wait_cycles++;
        end while (s_wb_rst_i && wait_cycles < 20);

        if (s_wb_rst_i) begin
            $display("reset was still asserted after 20 cycles");
            $display("STATUS: FAIL");
        end else begin
            foreach (table_q[i]) begin
                @(posedge s_wb_clk_i);
                #1;
                drive_row(table_q[i]);
                #2;
                // ack follows stb in the same cycle
                compare_value("s_wb_ack_o", s_wb_ack_o, {31'h0, s_wb_stb_i});
                if (table_q[i].op == OP_BUS_RD) begin
                    compare_value("s_wb_dat_o", s_wb_dat_o, table_q[i].exp_dat);
                end
                @(posedge s_wb_clk_i);
                #1;
                drive_row('0);
                verify_outputs(table_q[i]);
            end

            $display("rows: %0d, checks: %0d, errors: %0d", table_q.size(), checks, errors);
            if (errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

    // watchdog
    initial begin
        for (int i = 0; i < 4000; i++) begin
            @(posedge s_wb_clk_i);
        end
        $display("run did not finish within 4000 cycles");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== buf_manager.f ====
verilog/buf_mgr_pkg.sv
verilog/buf_writer_alloc.sv
verilog/buf_reader_alloc.sv
verilog/buf_refcnt_table.sv
verilog/buf_mgr_regs.sv
verilog/buf_manager.sv
sim/buf_mgr_clkgen.sv
sim/buf_manager_properties.sv
sim/buf_manager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module buf_manager_tb \
    -f buf_manager.f -o buf_manager_sim > build.log 2>&1 \
    && ./obj_dir/buf_manager_sim > sim.log 2>&1 \
    || echo "build or run ended with an error, see build.log" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
